// File: hw/psx_load_defines.svh
// Widths, base addresses and image indexes for the download path, included by each RTL file
`ifndef PSX_LOAD_DEFINES_SVH
`define PSX_LOAD_DEFINES_SVH

// ============================================================
// Bus widths
// ============================================================

// SDRAM byte address
`define PSX_ADDR_W 27
// Packed write word and host half word
`define PSX_DATA_W 32
`define PSX_HALF_W 16
`define PSX_BE_W 4

// ============================================================
// Host image selection
// ============================================================

`define PSX_INDEX_W 8
`define PSX_BIOS_INDEX 8'd0
`define PSX_EXE_INDEX 8'd1

// Load targets in SDRAM
`define PSX_BIOS_BASE 27'h020_0000
`define PSX_EXE_BASE 27'h040_0000

`endif

// File: hw/psx_load_pkg.sv
// Shared types of the download path, referenced by scoped name from the RTL stages
package psx_load_pkg;

	// ============================================================
	// Download kind
	// ============================================================

	// Which image the host is currently streaming
	typedef enum logic [1:0] {
		LOAD_NONE = 2'd0,
		LOAD_BIOS = 2'd1,
		LOAD_EXE  = 2'd2
	} load_kind_e;

endpackage

// File: hw/load_kind_decode.sv
// Stage 1 of the download path: registers the image kind, drives system reset and exe_start
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module load_kind_decode (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  logic                          host_download,
	input  logic [`PSX_INDEX_W-1:0]       host_index,
	output psx_load_pkg::load_kind_e      load_kind,
	output logic                          sys_reset,
	output logic                          exe_start
);

	psx_load_pkg::load_kind_e next_kind;
	psx_load_pkg::load_kind_e prev_kind;

	// ============================================================
	// Index decode
	// ============================================================

	// Unknown indexes are treated as no download at all
	always_comb begin
		next_kind = psx_load_pkg::LOAD_NONE;
		if (host_download) begin
			if (host_index == `PSX_BIOS_INDEX) begin
				next_kind = psx_load_pkg::LOAD_BIOS;
			end else if (host_index == `PSX_EXE_INDEX) begin
				next_kind = psx_load_pkg::LOAD_EXE;
			end
		end
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			load_kind <= psx_load_pkg::LOAD_NONE;
			prev_kind <= psx_load_pkg::LOAD_NONE;
		end else begin
			load_kind <= next_kind;
			prev_kind <= load_kind;
		end
	end

	// ============================================================
	// Status outputs
	// ============================================================

	// Core held in reset for the whole download
	assign sys_reset = (load_kind != psx_load_pkg::LOAD_NONE);

	// Falling edge of an executable download starts it
	assign exe_start = (prev_kind == psx_load_pkg::LOAD_EXE) &&
	                   (load_kind != psx_load_pkg::LOAD_EXE);

endmodule

// File: hw/load_word_packer.sv
// Stage 2 of the download path: packs host half words into SDRAM words and throttles the host
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module load_word_packer (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  psx_load_pkg::load_kind_e      load_kind,
	input  logic                          host_wr,
	input  logic [`PSX_ADDR_W-1:0]        host_addr,
	input  logic [`PSX_HALF_W-1:0]        host_data,
	output logic                          host_wait,
	output logic                          dl_valid,
	input  logic                          dl_ready,
	output logic [`PSX_ADDR_W-1:0]        dl_addr,
	output logic [`PSX_DATA_W-1:0]        dl_data
);

	logic                   active;
	logic                   lo_wr;
	logic                   hi_wr;
	logic [`PSX_ADDR_W-1:0] base_addr;

	// ============================================================
	// Write decode
	// ============================================================

	assign active = (load_kind != psx_load_pkg::LOAD_NONE);

	// Address bit 1 picks the half of the 32-bit word
	assign lo_wr = active && host_wr && !host_addr[1];
	assign hi_wr = active && host_wr && host_addr[1];

	// Only BIOS and executable reach here with writes enabled
	assign base_addr = (load_kind == psx_load_pkg::LOAD_EXE) ? `PSX_EXE_BASE : `PSX_BIOS_BASE;

	// ============================================================
	// Word assembly
	// ============================================================

	always_ff @(posedge clk_1x) begin
		if (lo_wr) begin
			dl_data[`PSX_HALF_W-1:0] <= host_data;
			dl_addr                  <= host_addr + base_addr;
		end
		if (hi_wr) begin
			dl_data[`PSX_DATA_W-1:`PSX_HALF_W] <= host_data;
		end
	end

	// ============================================================
	// Handshake and host throttle
	// ============================================================

	// After the word has left, dl_ready stays low until the SDRAM side
	// takes it out of the arbiter slot, so host_wait follows the memory
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_valid  <= 1'b0;
			host_wait <= 1'b0;
		end else if (!active) begin
			dl_valid  <= 1'b0;
			host_wait <= 1'b0;
		end else if (hi_wr) begin
			dl_valid  <= 1'b1;
			host_wait <= 1'b1;
		end else begin
			if (dl_valid && dl_ready) begin
				dl_valid <= 1'b0;
			end
			// Word already handed over, release the host once it drains
			if (host_wait && !dl_valid && dl_ready) begin
				host_wait <= 1'b0;
			end
		end
	end

endmodule

// File: hw/sdram_write_arbiter.sv
// Stage 3 of the download path: one-word write slot shared by download words and system writes
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module sdram_write_arbiter (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  psx_load_pkg::load_kind_e      load_kind,
	input  logic                          dl_valid,
	output logic                          dl_ready,
	input  logic [`PSX_ADDR_W-1:0]        dl_addr,
	input  logic [`PSX_DATA_W-1:0]        dl_data,
	input  logic                          sys_wr_valid,
	output logic                          sys_wr_ready,
	input  logic [`PSX_ADDR_W-1:0]        sys_wr_addr,
	input  logic [`PSX_DATA_W-1:0]        sys_wr_data,
	input  logic [`PSX_BE_W-1:0]          sys_wr_be,
	output logic                          sdram_wr_valid,
	input  logic                          sdram_wr_ready,
	output logic [`PSX_ADDR_W-1:0]        sdram_wr_addr,
	output logic [`PSX_DATA_W-1:0]        sdram_wr_data,
	output logic [`PSX_BE_W-1:0]          sdram_wr_be
);

	logic dl_active;
	logic slot_free;
	logic take_dl;
	logic take_sys;

	// ============================================================
	// Slot arbitration
	// ============================================================

	assign dl_active = (load_kind != psx_load_pkg::LOAD_NONE);

	// Empty, or draining this cycle
	assign slot_free = !sdram_wr_valid || sdram_wr_ready;

	// System port is shut out for the whole download
	assign dl_ready     = dl_active && slot_free;
	assign sys_wr_ready = !dl_active && slot_free;

	assign take_dl  = dl_valid && dl_ready;
	assign take_sys = sys_wr_valid && sys_wr_ready;

	// ============================================================
	// Output register
	// ============================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			sdram_wr_valid <= 1'b0;
		end else if (take_dl || take_sys) begin
			sdram_wr_valid <= 1'b1;
		end else if (sdram_wr_ready) begin
			sdram_wr_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (take_dl) begin
			sdram_wr_addr <= dl_addr;
			sdram_wr_data <= dl_data;
			sdram_wr_be   <= {`PSX_BE_W{1'b1}};
		end else if (take_sys) begin
			sdram_wr_addr <= sys_wr_addr;
			sdram_wr_data <= sys_wr_data;
			sdram_wr_be   <= sys_wr_be;
		end
	end

endmodule

// File: hw/psx_load_top.sv
// Top level of the image download path: host stream in, shared SDRAM write port out
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module psx_load_top (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	// Host download stream
	input  logic                          host_download,
	input  logic [`PSX_INDEX_W-1:0]       host_index,
	input  logic                          host_wr,
	input  logic [`PSX_ADDR_W-1:0]        host_addr,
	input  logic [`PSX_HALF_W-1:0]        host_data,
	output logic                          host_wait,
	// Emulated system writes
	input  logic                          sys_wr_valid,
	output logic                          sys_wr_ready,
	input  logic [`PSX_ADDR_W-1:0]        sys_wr_addr,
	input  logic [`PSX_DATA_W-1:0]        sys_wr_data,
	input  logic [`PSX_BE_W-1:0]          sys_wr_be,
	// SDRAM write channel
	output logic                          sdram_wr_valid,
	input  logic                          sdram_wr_ready,
	output logic [`PSX_ADDR_W-1:0]        sdram_wr_addr,
	output logic [`PSX_DATA_W-1:0]        sdram_wr_data,
	output logic [`PSX_BE_W-1:0]          sdram_wr_be,
	// Core control
	output logic                          sys_reset,
	output logic                          exe_start
);

	psx_load_pkg::load_kind_e load_kind;
	logic                     dl_valid;
	logic                     dl_ready;
	logic [`PSX_ADDR_W-1:0]   dl_addr;
	logic [`PSX_DATA_W-1:0]   dl_data;

	// ============================================================
	// Pipeline stages
	// ============================================================

	load_kind_decode decode0 (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.host_download (host_download),
		.host_index    (host_index),
		.load_kind     (load_kind),
		.sys_reset     (sys_reset),
		.exe_start     (exe_start)
	);

	load_word_packer packer0 (
		.clk_1x    (clk_1x),
		.arst_n    (arst_n),
		.load_kind (load_kind),
		.host_wr   (host_wr),
		.host_addr (host_addr),
		.host_data (host_data),
		.host_wait (host_wait),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data)
	);

	// Download kind also decides who owns the write slot
	sdram_write_arbiter arb0 (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.load_kind      (load_kind),
		.dl_valid       (dl_valid),
		.dl_ready       (dl_ready),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data),
		.sys_wr_valid   (sys_wr_valid),
		.sys_wr_ready   (sys_wr_ready),
		.sys_wr_addr    (sys_wr_addr),
		.sys_wr_data    (sys_wr_data),
		.sys_wr_be      (sys_wr_be),
		.sdram_wr_valid (sdram_wr_valid),
		.sdram_wr_ready (sdram_wr_ready),
		.sdram_wr_addr  (sdram_wr_addr),
		.sdram_wr_data  (sdram_wr_data),
		.sdram_wr_be    (sdram_wr_be)
	);

endmodule

// File: verif/tb_clock_gen.sv
// Clock and reset source for the download path testbench, instanced once by the testbench top
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_1x,
	output logic arst_n
);

	// 4 ns period
	initial begin
		clk_1x = 1'b0;
		forever #2 clk_1x = ~clk_1x;
	end

	// Reset held for 8 cycles, released on a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk_1x);
		arst_n <= 1'b1;
	end

endmodule

// File: verif/tb_load_checker.sv
// Testbench monitor: models the expected SDRAM writes and status outputs and compares them
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module tb_load_checker (
	input logic                    clk_1x,
	input logic                    arst_n,
	input logic                    host_download,
	input logic [`PSX_INDEX_W-1:0] host_index,
	input logic                    host_wr,
	input logic [`PSX_ADDR_W-1:0]  host_addr,
	input logic [`PSX_HALF_W-1:0]  host_data,
	input logic                    host_wait,
	input logic                    sys_wr_valid,
	input logic                    sys_wr_ready,
	input logic [`PSX_ADDR_W-1:0]  sys_wr_addr,
	input logic [`PSX_DATA_W-1:0]  sys_wr_data,
	input logic [`PSX_BE_W-1:0]    sys_wr_be,
	input logic                    sdram_wr_valid,
	input logic                    sdram_wr_ready,
	input logic [`PSX_ADDR_W-1:0]  sdram_wr_addr,
	input logic [`PSX_DATA_W-1:0]  sdram_wr_data,
	input logic [`PSX_BE_W-1:0]    sdram_wr_be,
	input logic                    sys_reset,
	input logic                    exe_start
);

	psx_load_pkg::load_kind_e kind;
	psx_load_pkg::load_kind_e prev_kind;
	logic [`PSX_ADDR_W-1:0]   exp_addr[$];
	logic [`PSX_DATA_W-1:0]   exp_data[$];
	logic [`PSX_BE_W-1:0]     exp_be[$];
	logic                     exp_dl[$];
	logic [`PSX_ADDR_W-1:0]   lo_addr;
	logic [`PSX_ADDR_W-1:0]   hold_addr;
	logic [`PSX_HALF_W-1:0]   lo_data;
	logic [`PSX_DATA_W-1:0]   hold_data;
	logic                     hold;
	logic                     wait_q;
	int                       dl_pending;
	int                       writes;
	int                       exe_pulses;
	int                       errors;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	// ============================================================
	// Per-cycle model, on the values held before each edge
	// ============================================================

	always @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			kind       = psx_load_pkg::LOAD_NONE;
			prev_kind  = psx_load_pkg::LOAD_NONE;
			hold       = 1'b0;
			wait_q     = 1'b0;
			dl_pending = 0;
		end else begin
			check_value("sys_reset", sys_reset, kind != psx_load_pkg::LOAD_NONE);
			check_value("exe_start", exe_start,
				prev_kind == psx_load_pkg::LOAD_EXE && kind != psx_load_pkg::LOAD_EXE);
			exe_pulses += exe_start;
			if (kind != psx_load_pkg::LOAD_NONE) begin
				check_value("sys_wr_ready", sys_wr_ready, 0);
			end
			// Stalled SDRAM word must not move
			if (hold) begin
				check_value("sdram_wr_valid", sdram_wr_valid, 1);
				check_value("sdram_wr_addr", sdram_wr_addr, hold_addr);
				check_value("sdram_wr_data", sdram_wr_data, hold_data);
			end
			if (wait_q && !host_wait && dl_pending != 0) begin
				report("host_wait fell before the download word was written to SDRAM");
			end
			if (sdram_wr_valid && sdram_wr_ready) begin
				if (exp_addr.size() == 0) begin
					report("SDRAM write appeared while no write was expected");
				end else begin
					if (!exp_dl[0] && kind != psx_load_pkg::LOAD_NONE) begin
						report("System write reached SDRAM during a download");
					end
					check_value("sdram_wr_addr", sdram_wr_addr, exp_addr.pop_front());
					check_value("sdram_wr_data", sdram_wr_data, exp_data.pop_front());
					check_value("sdram_wr_be", sdram_wr_be, exp_be.pop_front());
					dl_pending -= exp_dl.pop_front();
					writes++;
				end
			end
			if (sys_wr_valid && sys_wr_ready) begin
				exp_addr.push_back(sys_wr_addr);
				exp_data.push_back(sys_wr_data);
				exp_be.push_back(sys_wr_be);
				exp_dl.push_back(1'b0);
			end
			// Low half sets the address, high half completes the word
			if (host_wr && kind != psx_load_pkg::LOAD_NONE) begin
				if (!host_addr[1]) begin
					lo_addr = host_addr + ((kind == psx_load_pkg::LOAD_EXE) ?
						`PSX_EXE_BASE : `PSX_BIOS_BASE);
					lo_data = host_data;
				end else begin
					exp_addr.push_back(lo_addr);
					exp_data.push_back({host_data, lo_data});
					exp_be.push_back('1);
					exp_dl.push_back(1'b1);
					dl_pending++;
				end
			end
			hold      = sdram_wr_valid && !sdram_wr_ready;
			hold_addr = sdram_wr_addr;
			hold_data = sdram_wr_data;
			wait_q    = host_wait;
			prev_kind = kind;
			if (host_download && host_index == `PSX_BIOS_INDEX) begin
				kind = psx_load_pkg::LOAD_BIOS;
			end else if (host_download && host_index == `PSX_EXE_INDEX) begin
				kind = psx_load_pkg::LOAD_EXE;
			end else begin
				kind = psx_load_pkg::LOAD_NONE;
			end
		end
	end

	task automatic final_check(output int error_total);
		if (exp_addr.size() != 0) begin
			report($sformatf("%0d expected SDRAM writes never appeared", exp_addr.size()));
		end
		if (exe_pulses != 1) begin
			report($sformatf("Saw %0d exe_start pulses where one was expected", exe_pulses));
		end
		$display("Checker: %0d SDRAM writes compared, %0d exe_start pulses, %0d errors",
			writes, exe_pulses, errors);
		error_total = errors;
	endtask

endmodule

// File: verif/tb_psx_load.sv
// Testbench top: runs a BIOS and an executable download, then random system writes, into the DUT
`timescale 1ns/10ps
`include "psx_load_defines.svh"

module tb_psx_load;

	// Test length from 16 cycles per download word, the system phase and idle gaps
	localparam int TEST_CYCLES    = 2 * 64 * 16 + 200 + 64;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic                    clk_1x;
	logic                    arst_n;
	logic                    host_download;
	logic                    host_wr;
	logic                    host_wait;
	logic [`PSX_INDEX_W-1:0] host_index;
	logic [`PSX_ADDR_W-1:0]  host_addr;
	logic [`PSX_HALF_W-1:0]  host_data;
	logic                    sys_wr_valid;
	logic                    sys_wr_ready;
	logic [`PSX_ADDR_W-1:0]  sys_wr_addr;
	logic [`PSX_DATA_W-1:0]  sys_wr_data;
	logic [`PSX_BE_W-1:0]    sys_wr_be;
	logic                    sdram_wr_valid;
	logic                    sdram_wr_ready = 1'b0;
	logic [`PSX_ADDR_W-1:0]  sdram_wr_addr;
	logic [`PSX_DATA_W-1:0]  sdram_wr_data;
	logic [`PSX_BE_W-1:0]    sdram_wr_be;
	logic                    sys_reset;
	logic                    exe_start;
	logic [31:0]             stim_state = 32'hd9b8_8639;
	logic [31:0]             rdy_state = 32'hd9b8_8639;
	int                      cycle_count;
	int                      error_total;

	tb_clock_gen clkgen0 (.*);
	psx_load_top dut0 (.*);
	tb_load_checker checker0 (.*);

	// ============================================================
	// Random source
	// ============================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], stim_state[0]};
			stim_state = lfsr_next(stim_state);
		end
		return r;
	endfunction

	// SDRAM side accepts on random cycles
	always @(posedge clk_1x) begin
		sdram_wr_ready <= rdy_state[0];
		rdy_state      <= lfsr_next(rdy_state);
	end

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic run_download(input logic [`PSX_INDEX_W-1:0] index, input int words);
		int w;
		// Slot drained before the image stream starts
		@(posedge clk_1x);
		while (sdram_wr_valid) @(posedge clk_1x);
		host_download <= 1'b1;
		host_index    <= index;
		// System write stays offered for the whole download
		@(posedge clk_1x);
		sys_wr_valid <= 1'b1;
		sys_wr_addr  <= rand_bits(`PSX_ADDR_W);
		sys_wr_data  <= rand_bits(`PSX_DATA_W);
		sys_wr_be    <= rand_bits(`PSX_BE_W);
		for (w = 0; w < 2 * words; w++) begin
			repeat (rand_bits(2)) @(posedge clk_1x);
			@(posedge clk_1x);
			while (host_wait) @(posedge clk_1x);
			host_wr   <= 1'b1;
			host_addr <= w * 2;
			host_data <= rand_bits(`PSX_HALF_W);
			@(posedge clk_1x);
			host_wr <= 1'b0;
		end
		// Last word has to reach SDRAM first
		@(posedge clk_1x);
		while (host_wait) @(posedge clk_1x);
		host_download <= 1'b0;
		// Held system write goes through once the download is over
		@(posedge clk_1x);
		while (!sys_wr_ready) @(posedge clk_1x);
		sys_wr_valid <= 1'b0;
	endtask

	task automatic run_system_writes(input int cycles);
		int   n;
		logic pending;
		n = 0;
		pending = 1'b0;
		while (n < cycles || pending) begin
			@(posedge clk_1x);
			// New word only once the previous one was taken
			if (!pending || sys_wr_ready) begin
				pending = (n < cycles) && (rand_bits(1) != 0);
				sys_wr_valid <= pending;
				sys_wr_addr  <= rand_bits(`PSX_ADDR_W);
				sys_wr_data  <= rand_bits(`PSX_DATA_W);
				sys_wr_be    <= rand_bits(`PSX_BE_W);
			end
			n++;
		end
	endtask

	initial begin
		host_download <= 1'b0;
		host_index    <= '0;
		host_wr       <= 1'b0;
		host_addr     <= '0;
		host_data     <= '0;
		sys_wr_valid  <= 1'b0;
		sys_wr_addr   <= '0;
		sys_wr_data   <= '0;
		sys_wr_be     <= '0;
		wait (arst_n);
		run_download(`PSX_BIOS_INDEX, 64);
		repeat (8) @(posedge clk_1x);
		run_download(`PSX_EXE_INDEX, 64);
		repeat (8) @(posedge clk_1x);
		run_system_writes(200);
		@(posedge clk_1x);
		while (sdram_wr_valid) @(posedge clk_1x);
		repeat (4) @(posedge clk_1x);
		checker0.final_check(error_total);
		if (error_total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		for (cycle_count = 0; cycle_count < TIMEOUT_CYCLES; cycle_count++) @(posedge clk_1x);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+hw
hw/psx_load_pkg.sv
hw/load_kind_decode.sv
hw/load_word_packer.sv
hw/sdram_write_arbiter.sv
hw/psx_load_top.sv
verif/tb_clock_gen.sv
verif/tb_load_checker.sv
verif/tb_psx_load.sv
